/* common/core_consts.svh */
/*
 * Global constants of the two-stage RV32I core.
 * Include wherever widths, opcodes or the boot address are needed.
 */

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and register index widths
`define XLEN       32
`define REG_ADDR_W 5

// First fetch address after reset
`define BOOT_ADDR  32'h0000_0080

// RV32I major opcodes of the kept subset
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011

`endif

/* common/core_pkg.sv */
/*
 * Shared types of the core: word and index vectors plus the enums
 * for ALU operation, instruction class and controller state.
 */

`include "core_consts.svh"

package core_pkg;

  // Plain vectors with a meaning
  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]            instr_t;

  // ALU operations, PASS_B forwards operand b (LUI)
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

  // Instruction classes seen by execute
  typedef enum logic [2:0] {
    CLASS_NOP, CLASS_ALU_REG, CLASS_ALU_IMM, CLASS_LUI, CLASS_STORE, CLASS_BRANCH
  } op_class_e;

  // Run control
  typedef enum logic {CTRL_IDLE, CTRL_RUN} ctrl_state_e;

endpackage

/* src/register_file.sv */
/*
 * Register file, 31 writable 32-bit registers plus x0 tied to zero.
 * Two combinational read ports, one write port at the clock edge.
 */

`timescale 1ns/1ps

module register_file (
  input  logic                clk_i,
  input  logic                rst_i,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::word_t     rdata_a_o,
  output core_pkg::word_t     rdata_b_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::word_t     wdata_i
);
  import core_pkg::*;

  // x1 to x31 only
  word_t regs_q [1:31];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* controller/core_controller.sv */
/*
 * Run control of the core. Holds the core idle until fetch enable,
 * stalls on an ungranted store and flushes behind a taken branch.
 */

`timescale 1ns/1ps

module core_controller (
  input  logic clk_i,
  input  logic rst_i,
  input  logic fetch_enable_i,
  input  logic store_pending_i,
  input  logic data_gnt_i,
  input  logic branch_taken_i,
  output logic fetch_en_o,
  output logic stall_o,
  output logic flush_o,
  output logic core_sleep_o
);
  import core_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Next state, no way back to idle except reset
  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (fetch_enable_i) begin
          state_d = CTRL_RUN;
        end
      end
      CTRL_RUN: state_d = CTRL_RUN;
      default:  state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // PC may only move once running
  assign fetch_en_o   = (state_q == CTRL_RUN);
  assign core_sleep_o = (state_q == CTRL_IDLE);

  // Store waits in execute until granted
  assign stall_o = store_pending_i & ~data_gnt_i;

  // Drop the word fetched behind a taken branch
  assign flush_o = branch_taken_i & ~stall_o;

endmodule

/* fetch/if_stage.sv */
/*
 * Fetch stage. Drives the fetch address and captures the returned
 * word together with its PC and a valid bit for execute.
 */

`timescale 1ns/1ps

`include "core_consts.svh"

module if_stage (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             fetch_en_i,
  input  logic             stall_i,
  input  logic             flush_i,
  input  logic             branch_taken_i,
  input  core_pkg::word_t  branch_target_i,
  input  core_pkg::instr_t instr_rdata_i,
  output core_pkg::word_t  instr_addr_o,
  output core_pkg::word_t  pc_o,
  output core_pkg::instr_t instr_o,
  output logic             instr_valid_o
);
  import core_pkg::*;

  word_t  fetch_pc_q;
  word_t  fetch_pc_d;
  word_t  pc_q;
  instr_t instr_q;
  logic   valid_q;
  logic   advance;

  // Advance only when running and execute is not held
  assign advance = fetch_en_i & ~stall_i;

  // Branch target wins over sequential fetch
  assign fetch_pc_d = branch_taken_i ? branch_target_i : fetch_pc_q + word_t'(4);

  // Control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_pc_q <= `BOOT_ADDR;
      valid_q    <= 1'b0;
    end else if (advance) begin
      fetch_pc_q <= fetch_pc_d;
      valid_q    <= ~flush_i;
    end else if (!stall_i) begin
      // Idle, nothing fetched
      valid_q <= 1'b0;
    end
  end

  // Fetched word and its PC
  always_ff @(posedge clk_i) begin
    if (advance) begin
      instr_q <= instr_rdata_i;
      pc_q    <= fetch_pc_q;
    end
  end

  assign instr_addr_o  = fetch_pc_q;
  assign pc_o          = pc_q;
  assign instr_o       = instr_q;
  assign instr_valid_o = valid_q;

endmodule

/* decode/decoder.sv */
/*
 * Combinational decoder for the kept RV32I subset.
 * Unknown or invalid words decode to class NOP.
 */

`timescale 1ns/1ps

`include "core_consts.svh"

module decoder (
  input  core_pkg::instr_t    instr_i,
  input  logic                instr_valid_i,
  output core_pkg::op_class_e op_class_o,
  output core_pkg::alu_op_e   alu_op_o,
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  output core_pkg::reg_addr_t rd_addr_o,
  output core_pkg::word_t     imm_o,
  output logic                branch_ne_o
);
  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Immediates of each format, sign-extended to a word
  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_b_type;
  word_t imm_u_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register fields sit at fixed positions
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  assign rd_addr_o  = instr_i[11:7];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    op_class_o  = CLASS_NOP;
    alu_op_o    = ALU_ADD;
    imm_o       = imm_i_type;
    branch_ne_o = 1'b0;
    if (instr_valid_i) begin
      case (opcode)
        `OPC_OP: begin
          op_class_o = CLASS_ALU_REG;
          case ({funct7, funct3})
            {7'h00, 3'b000}: alu_op_o = ALU_ADD;
            {7'h20, 3'b000}: alu_op_o = ALU_SUB;
            {7'h00, 3'b100}: alu_op_o = ALU_XOR;
            {7'h00, 3'b110}: alu_op_o = ALU_OR;
            {7'h00, 3'b111}: alu_op_o = ALU_AND;
            {7'h00, 3'b010}: alu_op_o = ALU_SLT;
            default:         op_class_o = CLASS_NOP;
          endcase
        end
        `OPC_OP_IMM: begin
          // No SUB or SLTI here
          op_class_o = CLASS_ALU_IMM;
          case (funct3)
            3'b000:  alu_op_o = ALU_ADD;
            3'b100:  alu_op_o = ALU_XOR;
            3'b110:  alu_op_o = ALU_OR;
            3'b111:  alu_op_o = ALU_AND;
            default: op_class_o = CLASS_NOP;
          endcase
        end
        `OPC_LUI: begin
          op_class_o = CLASS_LUI;
          alu_op_o   = ALU_PASS_B;
          imm_o      = imm_u_type;
        end
        `OPC_STORE: begin
          // SW only, address through the adder
          if (funct3 == 3'b010) begin
            op_class_o = CLASS_STORE;
            alu_op_o   = ALU_ADD;
            imm_o      = imm_s_type;
          end
        end
        `OPC_BRANCH: begin
          // BEQ and BNE compare by subtraction
          if (funct3[2:1] == 2'b00) begin
            op_class_o  = CLASS_BRANCH;
            alu_op_o    = ALU_SUB;
            imm_o       = imm_b_type;
            branch_ne_o = funct3[0];
          end
        end
        default: op_class_o = CLASS_NOP;
      endcase
    end
  end

endmodule

/* execute/ex_stage.sv */
/*
 * Execute stage. ALU, branch compare and target, word store request
 * and write-back port, all combinational in the execute cycle.
 */

`timescale 1ns/1ps

`include "core_consts.svh"

module ex_stage (
  input  core_pkg::op_class_e op_class_i,
  input  core_pkg::alu_op_e   alu_op_i,
  input  core_pkg::reg_addr_t rd_addr_i,
  input  core_pkg::word_t     imm_i,
  input  core_pkg::word_t     pc_i,
  input  core_pkg::word_t     rs1_data_i,
  input  core_pkg::word_t     rs2_data_i,
  input  logic                branch_ne_i,
  input  logic                stall_i,
  output logic                rf_we_o,
  output core_pkg::reg_addr_t rf_waddr_o,
  output core_pkg::word_t     rf_wdata_o,
  output logic                data_req_o,
  output core_pkg::word_t     data_addr_o,
  output core_pkg::word_t     data_wdata_o,
  output logic                branch_taken_o,
  output core_pkg::word_t     branch_target_o
);
  import core_pkg::*;

  word_t operand_b;
  word_t alu_result;
  logic  slt;
  logic  operands_eq;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  // Register operand for R-type and branches, immediate otherwise
  assign operand_b = ((op_class_i == CLASS_ALU_REG) || (op_class_i == CLASS_BRANCH)) ?
                     rs2_data_i : imm_i;

  assign slt = $signed(rs1_data_i) < $signed(operand_b);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_result = rs1_data_i + operand_b;
      ALU_SUB:    alu_result = rs1_data_i - operand_b;
      ALU_AND:    alu_result = rs1_data_i & operand_b;
      ALU_OR:     alu_result = rs1_data_i | operand_b;
      ALU_XOR:    alu_result = rs1_data_i ^ operand_b;
      ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, slt};
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = '0;
    endcase
  end

  // Write-back, held off while a store waits
  assign rf_we_o    = ((op_class_i == CLASS_ALU_REG) || (op_class_i == CLASS_ALU_IMM) ||
                       (op_class_i == CLASS_LUI)) & ~stall_i;
  assign rf_waddr_o = rd_addr_i;
  assign rf_wdata_o = alu_result;

  //////////////////////////////////////////////////////////////////////
  // Store and branch
  //////////////////////////////////////////////////////////////////////

  // SW address from the adder, rs1 plus S immediate
  assign data_req_o   = (op_class_i == CLASS_STORE);
  assign data_addr_o  = alu_result;
  assign data_wdata_o = rs2_data_i;

  // Branch decoded as SUB, zero difference means equal
  assign operands_eq     = (alu_result == '0);
  assign branch_taken_o  = (op_class_i == CLASS_BRANCH) & (operands_eq ^ branch_ne_i);
  assign branch_target_o = pc_i + imm_i;

endmodule

/* src/core_top.sv */
/*
 * Top level of the two-stage RV32I core.
 * Connects controller, fetch, decode, register file and execute.
 */

`timescale 1ns/1ps

module core_top (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  // Instruction port, word returned in the same cycle
  output core_pkg::word_t  instr_addr_o,
  input  core_pkg::instr_t instr_rdata_i,
  // Data port, word stores only
  output logic            data_req_o,
  output core_pkg::word_t  data_addr_o,
  output core_pkg::word_t  data_wdata_o,
  input  logic            data_gnt_i,
  output logic            core_sleep_o
);
  import core_pkg::*;

  // Controller outputs
  logic fetch_en;
  logic stall;
  logic flush;

  // Fetch to decode and execute
  instr_t instr_q;
  logic   instr_valid;
  word_t  pc_q;

  // Decode to execute
  op_class_e op_class;
  alu_op_e   alu_op;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  word_t     imm;
  logic      branch_ne;

  // Register file
  word_t     rs1_data;
  word_t     rs2_data;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  // Branch resolution from execute
  logic  branch_taken;
  word_t branch_target;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  core_controller controller_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_enable_i  (fetch_enable_i),
    .store_pending_i (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .branch_taken_i  (branch_taken),
    .fetch_en_o      (fetch_en),
    .stall_o         (stall),
    .flush_o         (flush),
    .core_sleep_o    (core_sleep_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  if_stage if_stage_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_en_i      (fetch_en),
    .stall_i         (stall),
    .flush_i         (flush),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .instr_rdata_i   (instr_rdata_i),
    .instr_addr_o    (instr_addr_o),
    .pc_o            (pc_q),
    .instr_o         (instr_q),
    .instr_valid_o   (instr_valid)
  );

  decoder decoder_inst (
    .instr_i       (instr_q),
    .instr_valid_i (instr_valid),
    .op_class_o    (op_class),
    .alu_op_o      (alu_op),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rd_addr_o     (rd_addr),
    .imm_o         (imm),
    .branch_ne_o   (branch_ne)
  );

  register_file register_file_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  ex_stage ex_stage_inst (
    .op_class_i      (op_class),
    .alu_op_i        (alu_op),
    .rd_addr_i       (rd_addr),
    .imm_i           (imm),
    .pc_i            (pc_q),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .branch_ne_i     (branch_ne),
    .stall_i         (stall),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .data_req_o      (data_req_o),
    .data_addr_o     (data_addr_o),
    .data_wdata_o    (data_wdata_o),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target)
  );

endmodule

/* bench/core_asserts.sv */
/*
 * Concurrent checks on the core's port behavior.
 * Bound into every core_top instance.
 */

`timescale 1ns/1ps

module core_asserts (
  input logic            clk_i,
  input logic            rst_i,
  input logic            data_req_i,
  input logic            data_gnt_i,
  input core_pkg::word_t data_addr_i,
  input core_pkg::word_t data_wdata_i,
  input logic            core_sleep_i,
  input core_pkg::word_t instr_addr_i
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Waiting store keeps its request, address and data
  req_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_i && !data_gnt_i |=>
      data_req_i && $stable(data_addr_i) && $stable(data_wdata_i))
    else begin
      $error("store request changed while waiting for grant");
      fail_count++;
    end

  // No stores while asleep
  sleep_no_req_a: assert property (@(posedge clk_i) disable iff (rst_i)
    core_sleep_i |-> !data_req_i)
    else begin
      $error("store request raised while the core sleeps");
      fail_count++;
    end

  // Word fetches only
  fetch_aligned_a: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_addr_i[1:0] == 2'b00)
    else begin
      $error("instruction address not word aligned");
      fail_count++;
    end

endmodule

bind core_top core_asserts core_asserts_inst (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .data_req_i   (data_req_o),
  .data_gnt_i   (data_gnt_i),
  .data_addr_i  (data_addr_o),
  .data_wdata_i (data_wdata_o),
  .core_sleep_i (core_sleep_o),
  .instr_addr_i (instr_addr_o)
);

/* bench/core_checker.sv */
/*
 * Scoreboard of the bench. Runs an RV32I reference model over each
 * program to get the expected stores, then compares every granted
 * store and the sleep level, and prints one result line per test.
 */

`timescale 1ns/1ps

`include "core_consts.svh"

module core_checker #(
  parameter int PROG_LEN = 40
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      fetch_enable_i,
  input  logic                      core_sleep_i,
  input  logic                      data_req_i,
  input  logic                      data_gnt_i,
  input  core_pkg::word_t           data_addr_i,
  input  core_pkg::word_t           data_wdata_i,
  input  logic [PROG_LEN-1:0][31:0] prog_i,
  input  int                        test_id_i,
  input  logic                      test_start_i,
  input  logic                      test_end_i,
  output int                        errors_o,
  output int                        tests_failed_o
);
  import core_pkg::*;

  // Expected store stream of the current test
  word_t exp_addr [$];
  word_t exp_data [$];
  int    store_idx;
  int    test_errors;
  logic  enable_q;

  initial begin
    errors_o       = 0;
    tests_failed_o = 0;
    store_idx      = 0;
    test_errors    = 0;
    enable_q       = 1'b0;
  end

  function automatic string test_name(int id);
    case (id)
      0:       return "reset_idle";
      1:       return "alu_reg";
      2:       return "alu_imm_lui";
      3:       return "branch";
      default: return "backpressure";
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // RV32I results by funct3, alt selects SUB
  function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return '0;
    endcase
  endfunction

  // Walks the program by index until the closing self branch
  task automatic run_model();
    word_t  regs [32];
    instr_t ins;
    word_t  a;
    word_t  b;
    word_t  res;
    int     idx;
    logic   wr;
    exp_addr.delete();
    exp_data.delete();
    for (int r = 0; r < 32; r++)
      regs[r] = '0;
    idx = 0;
    while (idx < PROG_LEN - 1) begin
      ins = prog_i[idx];
      a   = regs[ins[19:15]];
      b   = regs[ins[24:20]];
      res = '0;
      wr  = 1'b0;
      idx++;
      case (ins[6:0])
        `OPC_OP: begin
          res = ref_alu(ins[14:12], ins[30], a, b);
          wr  = 1'b1;
        end
        `OPC_OP_IMM: begin
          res = ref_alu(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
          wr  = 1'b1;
        end
        `OPC_LUI: begin
          res = {ins[31:12], 12'b0};
          wr  = 1'b1;
        end
        `OPC_STORE: begin
          exp_addr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
          exp_data.push_back(b);
        end
        `OPC_BRANCH: begin
          // funct3 bit 0 turns BEQ into BNE
          if ((a == b) != ins[12])
            idx = idx - 1 +
                  int'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0})) / 4;
        end
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0)
        regs[ins[11:7]] = res;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  task automatic check_store();
    if (store_idx >= exp_addr.size()) begin
      $display("Test %s: extra store to %h that the model never makes",
               test_name(test_id_i), data_addr_i);
      test_errors++;
    end else begin
      if (data_addr_i !== exp_addr[store_idx]) begin
        $display("Error: %s store %0d address expected %h actual %h",
                 test_name(test_id_i), store_idx, exp_addr[store_idx], data_addr_i);
        test_errors++;
      end
      if (data_wdata_i !== exp_data[store_idx]) begin
        $display("Error: %s store %0d data expected %h actual %h",
                 test_name(test_id_i), store_idx, exp_data[store_idx], data_wdata_i);
        test_errors++;
      end
    end
    store_idx++;
  endtask

  task automatic finish_test();
    if (store_idx < exp_addr.size()) begin
      $display("Test %s: %0d of %0d expected stores never reached the data port",
               test_name(test_id_i), exp_addr.size() - store_idx, exp_addr.size());
      test_errors++;
    end
    $display("Test %s: %s, %0d stores, %0d errors", test_name(test_id_i),
             (test_errors == 0) ? "ok" : "FAILED", store_idx, test_errors);
    errors_o = errors_o + test_errors;
    if (test_errors != 0)
      tests_failed_o = tests_failed_o + 1;
  endtask

  // Sampled mid-cycle, away from both edges
  always @(negedge clk_i) begin
    if (test_start_i) begin
      run_model();
      store_idx   = 0;
      test_errors = 0;
    end
    if (rst_i) begin
      enable_q = 1'b0;
    end else begin
      // Asleep with no request until the state change after enable
      if (!enable_q && (core_sleep_i !== 1'b1 || data_req_i !== 1'b0)) begin
        $display("Error: %s idle sleep and request expected 1 and 0 actual %b and %b",
                 test_name(test_id_i), core_sleep_i, data_req_i);
        test_errors++;
      end
      if (enable_q && core_sleep_i !== 1'b0) begin
        $display("Error: %s core_sleep_o expected 0 actual %b",
                 test_name(test_id_i), core_sleep_i);
        test_errors++;
      end
      if (data_req_i === 1'b1 && data_gnt_i === 1'b1)
        check_store();
      enable_q = fetch_enable_i;
    end
    if (test_end_i)
      finish_test();
  end

endmodule

/* bench/tb_core.sv */
/*
 * Testbench top for the two-stage core. Generates a random program per
 * test, serves it as instruction memory, drives grant and enable, and
 * stops the run at a cycle limit. Comparing is done in core_checker.
 */

`timescale 1ns/1ps

`include "core_consts.svh"

module tb_core;
  import core_pkg::*;

  localparam int    PROG_LEN    = 40;
  localparam int    TEST_COUNT  = 5;
  // 8 cycles per instruction plus reset, idle and drain per test
  localparam int    CYCLE_LIMIT = TEST_COUNT * PROG_LEN * 8 + TEST_COUNT * 64;
  localparam word_t END_ADDR    = `BOOT_ADDR + 4 * (PROG_LEN - 1);

  logic   clk = 1'b0;
  logic   rst;
  logic   fetch_enable;
  word_t  instr_addr;
  instr_t instr_rdata;
  logic   data_req;
  word_t  data_addr;
  word_t  data_wdata;
  logic   data_gnt;
  logic   core_sleep;

  // Program and test control shared with the checker
  logic [PROG_LEN-1:0][31:0] prog;
  int                        test_id;
  logic                      test_start;
  logic                      test_end;
  int                        errors;
  int                        tests_failed;
  int                        cycle_count = 0;
  int unsigned               seed = 32'hd530;

  always #4 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // Instruction memory answers in the same cycle
  // ADDI x0 outside the program
  always_comb begin
    if (instr_addr >= `BOOT_ADDR && instr_addr <= END_ADDR)
      instr_rdata = prog[(instr_addr - `BOOT_ADDR) >> 2];
    else
      instr_rdata = 32'h0000_0013;
  end

  core_top core_top_inst (
    .clk_i          (clk),
    .rst_i          (rst),
    .fetch_enable_i (fetch_enable),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_gnt_i     (data_gnt),
    .core_sleep_o   (core_sleep)
  );

  core_checker #(.PROG_LEN(PROG_LEN)) core_checker_inst (
    .clk_i          (clk),
    .rst_i          (rst),
    .fetch_enable_i (fetch_enable),
    .core_sleep_i   (core_sleep),
    .data_req_i     (data_req),
    .data_gnt_i     (data_gnt),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .prog_i         (prog),
    .test_id_i      (test_id),
    .test_start_i   (test_start),
    .test_end_i     (test_end),
    .errors_o       (errors),
    .tests_failed_o (tests_failed)
  );

  //////////////////////////////////////////////////////////////////////
  // Program generation
  //////////////////////////////////////////////////////////////////////

  // One random instruction of the kept subset for slot idx
  function automatic instr_t make_instr(int kind, int idx);
    int          pick;
    int          cls;
    int          sel;
    int          target;
    logic [2:0]  f3;
    logic [12:0] boff;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    pick = $urandom % 10;
    imm  = 12'($urandom);
    rd   = 5'($urandom % 8);
    rs1  = 5'($urandom % 8);
    rs2  = 5'($urandom % 8);
    // Seed x1 to x7 first
    if (idx < 7)
      return {imm, 5'd0, 3'b000, 5'(idx + 1), `OPC_OP_IMM};
    // Closing BEQ x0, x0 to itself
    if (idx == PROG_LEN - 1)
      return {25'd0, `OPC_BRANCH};
    // Class mix per test with 0 reg, 1 imm, 2 LUI, 3 store, 4 branch
    case (kind)
      1:       cls = (pick < 6) ? 0 : 3;
      2:       cls = (pick < 4) ? 1 : ((pick < 6) ? 2 : 3);
      3:       cls = (pick < 4) ? 4 : ((pick < 6) ? 0 : 3);
      default: cls = pick % 5;
    endcase
    // sel 0 ADD, 1 SUB, 2 XOR, 3 OR, 4 AND, 5 SLT
    // No SUB or SLT as immediate
    sel = (cls == 0) ? $urandom % 6 : $urandom % 4;
    if (cls == 1 && sel != 0)
      sel = sel + 1;
    case (sel)
      0, 1:    f3 = 3'b000;
      2:       f3 = 3'b100;
      3:       f3 = 3'b110;
      4:       f3 = 3'b111;
      default: f3 = 3'b010;
    endcase
    // Forward only and at most to the closing branch
    target = idx + 1 + $urandom % (PROG_LEN - 1 - idx);
    boff   = 13'((target - idx) * 4);
    case (cls)
      0:       return {(sel == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, `OPC_OP};
      1:       return {imm, rs1, f3, rd, `OPC_OP_IMM};
      2:       return {20'($urandom), rd, `OPC_LUI};
      3:       return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
      default: return {boff[12], boff[10:5], rs2, rs1, 2'b00, pick[0],
                       boff[4:1], boff[11], `OPC_BRANCH};
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic run_test(int t);
    int hits;
    hits         = 0;
    rst          = 1'b1;
    fetch_enable = 1'b0;
    data_gnt     = 1'b1;
    test_id      = t;
    for (int i = 0; i < PROG_LEN; i++)
      prog[i] = make_instr(t, i);
    test_start = 1'b1;
    next_cycle();
    test_start = 1'b0;
    repeat (4) next_cycle();
    rst = 1'b0;
    // Idle window where the core must sleep
    repeat (8) next_cycle();
    fetch_enable = 1'b1;
    // Done once parked on the closing branch with no store waiting
    while (hits < 3) begin
      @(negedge clk);
      if (instr_addr == END_ADDR && data_req !== 1'b1)
        hits++;
      next_cycle();
      // Grant randomly low in the last test only
      data_gnt = (t == TEST_COUNT - 1) ? 1'($urandom % 2) : 1'b1;
    end
    test_end = 1'b1;
    next_cycle();
    test_end = 1'b0;
  endtask

  initial begin
    rst          = 1'b1;
    fetch_enable = 1'b0;
    data_gnt     = 1'b1;
    test_id      = 0;
    test_start   = 1'b0;
    test_end     = 1'b0;
    prog         = '0;
    void'($urandom(seed));
    // Begin just after an edge like every later test
    next_cycle();
    for (int t = 0; t < TEST_COUNT; t++)
      run_test(t);
    @(negedge clk);
    $display("Tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
             TEST_COUNT, tests_failed, errors,
             core_top_inst.core_asserts_inst.fail_count);
    if (tests_failed == 0 && errors == 0 &&
        core_top_inst.core_asserts_inst.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* project.f */
+incdir+common
common/core_pkg.sv
src/register_file.sv
controller/core_controller.sv
fetch/if_stage.sv
decode/decoder.sv
execute/ex_stage.sv
src/core_top.sv
bench/core_asserts.sv
bench/core_checker.sv
bench/tb_core.sv

/* Bender.yml */
package:
  name: rv32i_two_stage_core

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - src/register_file.sv
      - controller/core_controller.sv
      - fetch/if_stage.sv
      - decode/decoder.sv
      - execute/ex_stage.sv
      - src/core_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/core_asserts.sv
      - bench/core_checker.sv
      - bench/tb_core.sv
